/* flist.f */
verilog/upm_pkg.sv
verilog/upm_tdr.sv
verilog/upm_counter.sv
verilog/upm_fabric.sv
verilog/cbb_clk_gen.sv
verilog/cbb_wrapper.sv
verilog/upm_top.sv
sim/upm_chk.sv
sim/upm_tb.sv

/* run.sh */
#!/bin/sh
# build the clock monitor testbench with Verilator, run it, search for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module upm_tb -f flist.f -o upm_sim || exit 1
out=$(./obj_dir/upm_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "^Done: no errors$" && echo "simulation passed" || {
        echo "simulation failed"
        exit 1
}

/* sim/upm_chk.sv */
//----------------------------------------------------------------------
// status rules of the edge counter, bound into upm_counter
//----------------------------------------------------------------------
module upm_chk (
        input logic               tck,
        input logic               reset,
        input upm_pkg::upm_stat_t stat
);
        timeunit 1ns;
        timeprecision 1ps;
        import upm_pkg::*;

        logic [upm_count_w-1:0] count;
        int                     fail_cnt = 0;   // read by the testbench

        assign count = stat.count;

        // a run is either going or finished
        busy_done_excl: assert property (@(posedge tck) disable iff (reset)
                !(stat.busy && stat.done))
        else begin
                $error("busy and done high together");
                fail_cnt++;
        end

        // count frozen while idle, only a start may clear it
        count_hold: assert property (@(posedge tck) disable iff (reset)
                !stat.busy |=> stat.busy || $stable(count))
        else begin
                $error("count changed while not busy");
                fail_cnt++;
        end

        // reset leaves the counter idle
        reset_idle: assert property (@(posedge tck)
                reset |=> !stat.busy)
        else begin
                $error("busy high right after reset");
                fail_cnt++;
        end

endmodule

/* sim/upm_tb.sv */
//----------------------------------------------------------------------
// chain word is wrapper reg in bits 0..8 and fabric reg in bits 9..31
// every scan sets sel and counts are checked to within one edge
//----------------------------------------------------------------------
module upm_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import upm_pkg::*;

        // one table row where enable is always written as 1
        typedef struct packed {
                logic [3:0] div0;
                logic [3:0] div1;
                logic       clk_sel;
                logic [3:0] win_log2;
                logic       iso_n;
        } row_t;

        localparam int num_rows  = 6;
        localparam int max_polls = 48;          // readbacks allowed per run

        logic tck;
        logic reset;
        logic iso_n;
        logic capture;
        logic shift;
        logic update;
        logic sel;
        logic si;
        logic so;

        row_t rows [num_rows];
        int   value_errs = 0;
        int   unfinished_errs = 0;
        int   cycles = 0;
        int   limit = 0;                        // 0 until worked out

        upm_top UUT (
                .tck     (tck),
                .reset   (reset),
                .iso_n   (iso_n),
                .capture (capture),
                .shift   (shift),
                .update  (update),
                .sel     (sel),
                .si      (si),
                .so      (so)
        );

        bind upm_counter upm_chk counter_chk (.tck(tck), .reset(reset), .stat(stat));

        initial begin
                tck = 1'b0;
                forever #20 tck = ~tck;         // 40 ns period
        end

        //--------------------------------------------------------------
        // watchdog
        //--------------------------------------------------------------
        always @(posedge tck) begin
                cycles <= cycles + 1;
                if (limit > 0 && cycles >= limit) begin
                        $display("timeout: no end of test after %0d cycles", cycles);
                        $display("errors: %0d wrong values, %0d unfinished", value_errs,
                                 unfinished_errs + 1);
                        $display("Done: errors found");
                        $finish;
                end
        end

        task automatic report_mismatch(input string name, input int got, input int exp);
                $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
                value_errs++;
        endtask

        // config write word with fields placed by hand
        function automatic logic [31:0] make_word(input row_t r, input logic start);
                make_word = {17'd0, start, r.clk_sel, r.win_log2, 1'b1, r.div0, r.div1};
        endfunction

        // optional capture then 32 shifts lsb first then optional update
        task automatic scan_word(input logic [31:0] din, input logic cap, input logic upd,
                                 output logic [31:0] dout);
                logic [31:0] got;
                int          i;
                got = '0;
                @(posedge tck);
                sel     <= 1'b1;
                capture <= cap;
                @(posedge tck);                 // capture taken here
                capture <= 1'b0;
                shift   <= 1'b1;
                si      <= din[0];
                for (i = 0; i < upm_chain_len; i++) begin
                        @(negedge tck);
                        got[i] = so;            // stable mid cycle
                        @(posedge tck);
                        if (i < upm_chain_len - 1) begin
                                si <= din[i+1];
                        end else begin
                                shift  <= 1'b0;
                                update <= upd;
                        end
                end
                @(posedge tck);                 // update edge
                update <= 1'b0;
                sel    <= 1'b0;
                dout = got;
        endtask

        // read back until done shows up
        task automatic poll_done(output logic [31:0] rd, output logic ok);
                int n;
                ok = 1'b0;
                n  = 0;
                rd = '0;
                while (!ok && n < max_polls) begin
                        scan_word(32'd0, 1'b1, 1'b0, rd);
                        ok = rd[30];
                        n++;
                end
        endtask

        task automatic check_result(input row_t r, input logic [31:0] rd);
                int         w;
                int         p;
                int         cnt;
                logic [8:0] cfg_exp;
                w       = (r.win_log2 < 4) ? 16 : (1 << r.win_log2);
                p       = r.clk_sel ? 2 * (r.div1 + 1) : 2 * (r.div0 + 1);
                cnt     = int'(rd[28:9]);
                cfg_exp = {1'b1, r.div0, r.div1};
                if (rd[8:0] != cfg_exp) report_mismatch("cfg", int'(rd[8:0]), int'(cfg_exp));
                if (rd[31] != 1'b0) report_mismatch("busy", int'(rd[31]), 0);
                if (rd[30] != 1'b1) report_mismatch("done", int'(rd[30]), 1);
                if (rd[29] != !r.iso_n) report_mismatch("pwr_err", int'(rd[29]), int'(!r.iso_n));
                if (!r.iso_n) begin
                        if (cnt != 0) report_mismatch("count", cnt, 0);  // clocks held
                end else if (cnt * p > w + p || cnt * p + p < w) begin
                        report_mismatch("count", cnt, w / p);
                end
        endtask

        //--------------------------------------------------------------
        // main sequence
        //--------------------------------------------------------------
        initial begin
                logic [31:0] rd;
                logic        ok;
                int          i;
                int          sum;
                int          errs;
                row_t        long_run;
                row_t        short_run;
                reset   = 1'b1;
                iso_n   = 1'b1;
                capture = 1'b0;
                shift   = 1'b0;
                update  = 1'b0;
                sel     = 1'b0;
                si      = 1'b0;
                //         div0  div1  sel   win   iso_n
                rows[0] = '{4'd1, 4'd3, 1'b0, 4'd6, 1'b1};
                rows[1] = '{4'd2, 4'd0, 1'b1, 4'd7, 1'b1};
                rows[2] = '{4'd4, 4'd5, 1'b0, 4'd8, 1'b0};    // isolated
                rows[3] = '{4'd3, 4'd6, 1'b1, 4'd9, 1'b1};    // error clears
                rows[4] = '{4'd0, 4'd2, 1'b0, 4'd10, 1'b1};
                rows[5] = '{4'd7, 4'd15, 1'b1, 4'd10, 1'b1};
                long_run  = '{4'd2, 4'd1, 1'b0, 4'd12, 1'b1};
                short_run = '{4'd1, 4'd4, 1'b1, 4'd7, 1'b1};
                // budget for rows and restart case plus reset and first readback
                sum = 0;
                for (i = 0; i < num_rows; i++) begin
                        sum += (1 << rows[i].win_log2) + 40 * max_polls;
                end
                sum += (1 << short_run.win_log2) + 40 * max_polls + 3 * 40;
                limit = 2 * (sum + 10 + 40);

                repeat (10) @(posedge tck);
                reset <= 1'b0;
                @(negedge tck);
                if (so != 1'b0) report_mismatch("so", int'(so), 0);
                scan_word(32'd0, 1'b1, 1'b0, rd);
                if (rd != 32'd0) report_mismatch("reset readback", int'(rd), 0);

                for (i = 0; i < num_rows; i++) begin
                        @(posedge tck);
                        iso_n <= rows[i].iso_n;
                        scan_word(make_word(rows[i], 1'b1), 1'b0, 1'b1, rd);
                        poll_done(rd, ok);
                        if (!ok) begin
                                $display("measurement in row %0d did not finish", i);
                                unfinished_errs++;
                        end else begin
                                check_result(rows[i], rd);
                        end
                end

                // second start lands mid window
                scan_word(make_word(long_run, 1'b1), 1'b0, 1'b1, rd);
                scan_word(32'd0, 1'b1, 1'b0, rd);
                if (rd[31] != 1'b1) report_mismatch("busy mid run", int'(rd[31]), 1);
                scan_word(make_word(short_run, 1'b1), 1'b0, 1'b1, rd);
                poll_done(rd, ok);
                if (!ok) begin
                        $display("restarted measurement did not finish");
                        unfinished_errs++;
                end else begin
                        check_result(short_run, rd);
                end

                errs = value_errs + unfinished_errs + UUT.upm1.counter.counter_chk.fail_cnt;
                $display("errors: %0d wrong values, %0d unfinished, %0d assertion", value_errs,
                         unfinished_errs, UUT.upm1.counter.counter_chk.fail_cnt);
                if (errs == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

/* verilog/cbb_clk_gen.sv */
//----------------------------------------------------------------------
// output is a tck-derived level toggling every div+1 cycles
//----------------------------------------------------------------------
module cbb_clk_gen (
        input  logic                          tck,
        input  logic                          reset,
        input  logic                          restart,
        input  logic                          run,
        input  logic [upm_pkg::cbb_div_w-1:0] div,
        output logic                          clk_out
);
        import upm_pkg::*;

        logic [cbb_div_w-1:0] cnt;      // cycles to next toggle
        logic                 clk_q;

        //--------------------------------------------------------------
        // divider
        //--------------------------------------------------------------
        always_ff @(posedge tck) begin
                if (reset) begin
                        cnt   <= '0;
                        clk_q <= 1'b0;
                end else if (restart) begin
                        // new config, start from low
                        cnt   <= div;
                        clk_q <= 1'b0;
                end else if (!run) begin
                        cnt   <= div;   // parked low
                        clk_q <= 1'b0;
                end else if (cnt == '0) begin
                        cnt   <= div;
                        clk_q <= ~clk_q;
                end else begin
                        cnt   <= cnt - cbb_div_w'(1);
                end
        end

        assign clk_out = clk_q;

endmodule

/* verilog/cbb_wrapper.sv */
//----------------------------------------------------------------------
// one model for every clock block flavour, dividers off while iso_n low
// power enable error holds until the next update or reset
//----------------------------------------------------------------------
module cbb_wrapper (
        input  logic               tck,
        input  logic               reset,
        input  upm_pkg::upm_scan_t strobe,
        input  logic               si,
        input  logic               iso_n,
        output logic [1:0]         clk_out,
        output logic               so,
        output logic               power_enable_error
);
        import upm_pkg::*;

        cbb_cfg_t cfg;          // divider settings from the chain
        logic     run;
        logic     pwr_err;

        // wrapper register, config is also what gets captured
        upm_tdr #(
                .update_t  (cbb_cfg_t),
                .capture_t (cbb_cfg_t)
        ) cfg_tdr (
                .tck         (tck),
                .reset       (reset),
                .strobe      (strobe),
                .si          (si),
                .capture_val (cfg),
                .so          (so),
                .update_val  (cfg)
        );

        //--------------------------------------------------------------
        // dividers
        //--------------------------------------------------------------
        assign run = cfg.enable & iso_n;        // isolated -> both held low

        cbb_clk_gen clk_gen0 (
                .tck     (tck),
                .reset   (reset),
                .restart (strobe.update),
                .run     (run),
                .div     (cfg.div0),
                .clk_out (clk_out[0])
        );

        cbb_clk_gen clk_gen1 (
                .tck     (tck),
                .reset   (reset),
                .restart (strobe.update),
                .run     (run),
                .div     (cfg.div1),
                .clk_out (clk_out[1])
        );

        // enabled while isolated is an error, sticky
        always_ff @(posedge tck) begin
                if (reset) begin
                        pwr_err <= 1'b0;
                end else if (strobe.update) begin
                        pwr_err <= 1'b0;        // cleared by new config
                end else if (cfg.enable && !iso_n) begin
                        pwr_err <= 1'b1;
                end
        end

        assign power_enable_error = pwr_err;

endmodule

/* verilog/upm_counter.sv */
//----------------------------------------------------------------------
// counts rising edges of the selected clock over 2^win_log2 tck
// window below 2^4 is raised to 2^4, a new start restarts at once
//----------------------------------------------------------------------
module upm_counter (
        input  logic               tck,
        input  logic               reset,
        input  upm_pkg::upm_ctrl_t ctrl,
        input  logic               ctrl_load,
        input  logic [1:0]         clk_in,
        output upm_pkg::upm_stat_t stat
);
        import upm_pkg::*;

        localparam int win_cnt_w = 2 ** upm_win_w;     // holds 2^15 - 1

        logic                   start;
        logic [upm_win_w-1:0]   win_eff;        // clamped exponent
        logic [win_cnt_w-1:0]   win_cnt;        // cycles left in window
        logic                   sel_q;          // clock select for this run
        logic [1:0]             clk_q;          // last sampled clock levels
        logic [1:0]             rise;
        logic                   busy;
        logic                   done;
        logic [upm_count_w-1:0] count;

        // start only when the control reg was just loaded
        assign start   = ctrl_load & ctrl.start;
        assign win_eff = (ctrl.win_log2 < upm_win_w'(4)) ? upm_win_w'(4) : ctrl.win_log2;

        //--------------------------------------------------------------
        // edge detect on both generated clocks
        //--------------------------------------------------------------
        always_ff @(posedge tck) begin
                if (reset) begin
                        clk_q <= '0;
                end else begin
                        clk_q <= clk_in;
                end
        end

        assign rise = clk_in & ~clk_q;          // level went 0 -> 1

        //--------------------------------------------------------------
        // window and edge counters
        //--------------------------------------------------------------
        always_ff @(posedge tck) begin
                if (reset) begin
                        busy    <= 1'b0;
                        done    <= 1'b0;
                        count   <= '0;
                        win_cnt <= '0;
                        sel_q   <= 1'b0;
                end else if (start) begin
                        // fresh run, also when already busy
                        busy    <= 1'b1;
                        done    <= 1'b0;
                        count   <= '0;
                        sel_q   <= ctrl.clk_sel;
                        win_cnt <= (win_cnt_w'(1) << win_eff) - win_cnt_w'(1);
                end else if (busy) begin
                        if (rise[sel_q]) begin
                                count <= count + upm_count_w'(1);
                        end
                        if (win_cnt == '0) begin
                                busy <= 1'b0;   // window over
                                done <= 1'b1;   // count now held
                        end else begin
                                win_cnt <= win_cnt - win_cnt_w'(1);
                        end
                end
        end

        // pwr_err comes from the wrapper, merged in the fabric
        always_comb begin
                stat.busy    = busy;
                stat.done    = done;
                stat.pwr_err = 1'b0;
                stat.count   = count;
        end

endmodule

/* verilog/upm_fabric.sv */
//----------------------------------------------------------------------
// strobes are gated by sel here, the wrapper only sees the result
// ctrl_load trails a qualified update by one tck
//----------------------------------------------------------------------
module upm_fabric (
        input  logic               tck,
        input  logic               reset,
        input  logic               capture,
        input  logic               shift,
        input  logic               update,
        input  logic               sel,
        input  logic               si,
        input  logic [1:0]         cbb_clk_in,
        input  logic               reg_so,
        input  logic               cbb_power_en_error,
        output upm_pkg::upm_scan_t scan_out,
        output logic               reg_si,
        output logic               so
);
        import upm_pkg::*;

        upm_scan_t scan_q;      // strobes after sel
        upm_ctrl_t ctrl;        // measurement control reg
        upm_stat_t cnt_stat;    // status from the counter
        upm_stat_t stat_cap;    // status with wrapper error merged
        logic      ctrl_load;

        //--------------------------------------------------------------
        // strobe qualification
        //--------------------------------------------------------------
        always_comb begin
                scan_q.capture = capture & sel;
                scan_q.shift   = shift & sel;
                scan_q.update  = update & sel;
        end

        assign scan_out = scan_q;       // same strobes go to the wrapper

        // ctrl reg is valid now, tell the counter
        always_ff @(posedge tck) begin
                if (reset) begin
                        ctrl_load <= 1'b0;
                end else begin
                        ctrl_load <= scan_q.update;
                end
        end

        always_comb begin
                stat_cap         = cnt_stat;
                stat_cap.pwr_err = cbb_power_en_error;
        end

        // fabric register, first in the chain after si
        upm_tdr #(
                .update_t  (upm_ctrl_t),
                .capture_t (upm_stat_t)
        ) ctrl_tdr (
                .tck         (tck),
                .reset       (reset),
                .strobe      (scan_q),
                .si          (si),
                .capture_val (stat_cap),
                .so          (reg_si),          // on to the wrapper reg
                .update_val  (ctrl)
        );

        upm_counter counter (
                .tck       (tck),
                .reset     (reset),
                .ctrl      (ctrl),
                .ctrl_load (ctrl_load),
                .clk_in    (cbb_clk_in),
                .stat      (cnt_stat)
        );

        assign so = reg_so;     // chain tail comes back from the wrapper

endmodule

/* verilog/upm_pkg.sv */
//----------------------------------------------------------------------
// field widths shared by all packed structs below
// chain word has the wrapper register in bits 0..8 and fabric above it
//----------------------------------------------------------------------
package upm_pkg;

        localparam int upm_count_w = 20;        // edge count width
        localparam int upm_win_w   = 4;         // window exponent width
        localparam int cbb_div_w   = 4;         // divider setting width

        // scan strobes as qualified by sel in the fabric
        typedef struct packed {
                logic capture;
                logic shift;
                logic update;
        } upm_scan_t;

        // measurement control loaded from the fabric register
        typedef struct packed {
                logic                 start;    // go on update
                logic                 clk_sel;  // generated clock 0 or 1
                logic [upm_win_w-1:0] win_log2; // window 2^n tck, min 4
        } upm_ctrl_t;

        //--------------------------------------------------------------
        // status captured into the fabric register
        //--------------------------------------------------------------
        typedef struct packed {
                logic                   busy;
                logic                   done;
                logic                   pwr_err;  // from the wrapper
                logic [upm_count_w-1:0] count;
        } upm_stat_t;

        // clock block config read back as written
        typedef struct packed {
                logic                 enable;
                logic [cbb_div_w-1:0] div0;     // clk0 toggles every div0+1
                logic [cbb_div_w-1:0] div1;     // clk1 toggles every div1+1
        } cbb_cfg_t;

        // fabric stage (23) plus wrapper stage (9)
        localparam int upm_chain_len = $bits(upm_stat_t) + $bits(cbb_cfg_t);

endpackage

/* verilog/upm_tdr.sv */
//----------------------------------------------------------------------
// shift stage is as long as the wider payload, capture zero-extended
// strobe priority capture > shift > update, all sampled on rising tck
//----------------------------------------------------------------------
module upm_tdr #(
        parameter type update_t  = logic,
        parameter type capture_t = logic
) (
        input  logic               tck,
        input  logic               reset,
        input  upm_pkg::upm_scan_t strobe,
        input  logic               si,
        input  capture_t           capture_val,
        output logic               so,
        output update_t            update_val
);

        localparam int upd_w = $bits(update_t);
        localparam int cap_w = $bits(capture_t);
        localparam int len   = (upd_w > cap_w) ? upd_w : cap_w;

        logic [len-1:0] stage;          // shift stage
        logic [len-1:0] cap_ext;        // capture payload padded to len
        logic           do_update;

        // pad the capture payload with zeros on top
        always_comb begin
                cap_ext = '0;
                cap_ext[cap_w-1:0] = capture_val;
        end

        //--------------------------------------------------------------
        // shift stage
        //--------------------------------------------------------------
        always_ff @(posedge tck) begin
                if (reset) begin
                        stage <= '0;
                end else if (strobe.capture) begin
                        stage <= cap_ext;
                end else if (strobe.shift) begin
                        stage <= {si, stage[len-1:1]};  // lsb leaves first
                end
        end

        // update loses to capture and shift
        assign do_update = strobe.update & ~strobe.capture & ~strobe.shift;

        // payload register, valid the cycle after the update edge
        always_ff @(posedge tck) begin
                if (reset) begin
                        update_val <= '0;
                end else if (do_update) begin
                        update_val <= update_t'(stage[upd_w-1:0]);
                end
        end

        assign so = stage[0];   // serial out to next stage

endmodule

/* verilog/upm_top.sv */
//----------------------------------------------------------------------
// all logic runs on tck, reset is synchronous active high
//----------------------------------------------------------------------
module upm_top (
        input  logic tck,
        input  logic reset,
        input  logic iso_n,
        input  logic capture,
        input  logic shift,
        input  logic update,
        input  logic sel,
        input  logic si,
        output logic so
);
        import upm_pkg::*;

        upm_scan_t  scan;               // qualified strobes to the wrapper
        logic       reg_si;             // fabric reg -> wrapper reg
        logic       reg_so;             // wrapper reg -> chain out
        logic [1:0] cbb_clk;            // generated clocks
        logic       cbb_pwr_err;

        //--------------------------------------------------------------
        // monitor fabric
        //--------------------------------------------------------------
        upm_fabric upm1 (
                .tck                (tck),
                .reset              (reset),
                .capture            (capture),
                .shift              (shift),
                .update             (update),
                .sel                (sel),
                .si                 (si),
                .cbb_clk_in         (cbb_clk),
                .reg_so             (reg_so),
                .cbb_power_en_error (cbb_pwr_err),
                .scan_out           (scan),
                .reg_si             (reg_si),
                .so                 (so)
        );

        // clock source, last in the chain
        cbb_wrapper cbb_wrap (
                .tck                (tck),
                .reset              (reset),
                .strobe             (scan),
                .si                 (reg_si),
                .iso_n              (iso_n),
                .clk_out            (cbb_clk),
                .so                 (reg_so),
                .power_enable_error (cbb_pwr_err)
        );

endmodule
